// File: logic/soc_pkg.sv
// ----------------------------------------------------------
// Peripheral subsystem shared definitions
// Bus types, address map, register offsets and byte merge
// ----------------------------------------------------------
package soc_pkg;

    // Bus and register types
    typedef logic [15:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [3:0]  apb_strb_t;
    typedef logic [3:0]  region_t;
    typedef logic [11:0] reg_ofs_t;
    typedef logic [63:0] mtime_t;
    typedef logic [3:0]  irq_src_t;

    // Slave chosen by the address decoder
    typedef enum logic [1:0] {
        SEL_SRAM,
        SEL_CLINT,
        SEL_IRQ,
        SEL_NONE
    } slave_sel_e;

    // ----------------------------------------------------------
    // Address map, value of paddr[15:12]
    localparam region_t REGION_SRAM  = 4'd0;
    localparam region_t REGION_CLINT = 4'd1;
    localparam region_t REGION_IRQ   = 4'd2;

    localparam int unsigned SRAM_WORDS = 256;
    localparam int unsigned SRAM_IDX_W = $clog2(SRAM_WORDS);

    // CLINT register offsets
    localparam reg_ofs_t MSIP_OFS        = 12'h000;
    localparam reg_ofs_t MTIMECMP_LO_OFS = 12'h008;
    localparam reg_ofs_t MTIMECMP_HI_OFS = 12'h00C;
    localparam reg_ofs_t MTIME_LO_OFS    = 12'h010;
    localparam reg_ofs_t MTIME_HI_OFS    = 12'h014;

    // Interrupt controller register offsets
    localparam reg_ofs_t PENDING_OFS = 12'h000;
    localparam reg_ofs_t ENABLE_OFS  = 12'h004;
    localparam reg_ofs_t CLAIM_OFS   = 12'h008;

    // Replace only the strobed bytes of a word
    function automatic apb_data_t strb_merge(apb_data_t old_d, apb_data_t new_d,
                                             apb_strb_t strb);
        apb_data_t res;
        res = old_d;
        for (int i = 0; i < $bits(apb_strb_t); i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_d[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

// File: logic/apb_xbar.sv
// ----------------------------------------------------------
// APB address decoder
// Selects one slave and returns its read data or an error
// ----------------------------------------------------------
`timescale 1ns/1ps

module apb_xbar
    import soc_pkg::*;
(
    input  apb_addr_t paddr_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  apb_data_t sram_rdata_i,
    input  apb_data_t clint_rdata_i,
    input  apb_data_t irq_rdata_i,
    output logic      sram_psel_o,
    output logic      clint_psel_o,
    output logic      irq_psel_o,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    slave_sel_e sel;
    region_t    region;
    logic       access;

    assign region = paddr_i[15:12];
    assign access = psel_i & penable_i;

    // ----------------------------------------------------------
    // Decode
    always_comb begin
        case (region)
            REGION_SRAM: begin
                // Upper offset bits beyond the memory size are a hole
                if (paddr_i[11:SRAM_IDX_W+2] != '0) begin
                    sel = SEL_NONE;
                end else begin
                    sel = SEL_SRAM;
                end
            end
            REGION_CLINT: sel = SEL_CLINT;
            REGION_IRQ:   sel = SEL_IRQ;
            default:      sel = SEL_NONE;
        endcase
    end

    // Only the decoded slave sees psel
    assign sram_psel_o  = psel_i && (sel == SEL_SRAM);
    assign clint_psel_o = psel_i && (sel == SEL_CLINT);
    assign irq_psel_o   = psel_i && (sel == SEL_IRQ);

    // ----------------------------------------------------------
    // Response
    always_comb begin
        prdata_o = '0;
        if (access) begin
            case (sel)
                SEL_SRAM:  prdata_o = sram_rdata_i;
                SEL_CLINT: prdata_o = clint_rdata_i;
                SEL_IRQ:   prdata_o = irq_rdata_i;
                default:   prdata_o = '0;
            endcase
        end
    end

    // Zero wait states everywhere
    assign pready_o  = access;
    assign pslverr_o = access && (sel == SEL_NONE);

endmodule

// File: logic/apb_sram.sv
// ----------------------------------------------------------
// Word memory on APB with byte strobes
// ----------------------------------------------------------
`timescale 1ns/1ps

module apb_sram
    import soc_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    input  apb_strb_t pstrb_i,
    output apb_data_t rdata_o
);

    apb_data_t             mem [0:SRAM_WORDS-1];
    apb_data_t             rdata_q;
    logic [SRAM_IDX_W-1:0] idx;
    logic                  wr_en;
    logic                  rd_en;

    // Word index from the byte address
    assign idx = paddr_i[SRAM_IDX_W+1:2];

    // Writes land in the access cycle, reads are fetched in setup
    assign wr_en = psel_i & penable_i & pwrite_i;
    assign rd_en = psel_i & ~penable_i & ~pwrite_i;

    // ----------------------------------------------------------
    // Storage
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[idx] <= strb_merge(mem[idx], pwdata_i, pstrb_i);
        end
    end

    // Read register, presented during the access cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_q <= '0;
        end else if (rd_en) begin
            rdata_q <= mem[idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: logic/clint.sv
// ----------------------------------------------------------
// Core-local interruptor
// Machine timer with compare and a software interrupt bit
// ----------------------------------------------------------
`timescale 1ns/1ps

module clint
    import soc_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      rtc_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    input  apb_strb_t pstrb_i,
    output apb_data_t rdata_o,
    output logic      timer_irq_o,
    output logic      soft_irq_o
);

    logic [2:0] rtc_q;
    logic       rtc_rise;
    mtime_t     mtime_q;
    mtime_t     mtimecmp_q;
    logic       msip_q;
    reg_ofs_t   ofs;
    logic       wr_en;

    assign ofs   = paddr_i[11:0];
    assign wr_en = psel_i & penable_i & pwrite_i;

    // ----------------------------------------------------------
    // RTC tick
    // Two flops for the clock crossing, third one for the edge
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rtc_q <= '0;
        end else begin
            rtc_q <= {rtc_q[1:0], rtc_i};
        end
    end

    assign rtc_rise = rtc_q[1] & ~rtc_q[2];

    // Free running, not writable from the bus
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime_q <= '0;
        end else if (rtc_rise) begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // ----------------------------------------------------------
    // Register writes
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtimecmp_q <= '1;
            msip_q     <= 1'b0;
        end else if (wr_en) begin
            case (ofs)
                MSIP_OFS: begin
                    if (pstrb_i[0]) begin
                        msip_q <= pwdata_i[0];
                    end
                end
                MTIMECMP_LO_OFS: begin
                    mtimecmp_q[31:0] <= strb_merge(mtimecmp_q[31:0], pwdata_i, pstrb_i);
                end
                MTIMECMP_HI_OFS: begin
                    mtimecmp_q[63:32] <= strb_merge(mtimecmp_q[63:32], pwdata_i, pstrb_i);
                end
                default: begin
                    // Unmapped or read-only, nothing to update
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Read mux
    always_comb begin
        case (ofs)
            MSIP_OFS:        rdata_o = apb_data_t'(msip_q);
            MTIMECMP_LO_OFS: rdata_o = mtimecmp_q[31:0];
            MTIMECMP_HI_OFS: rdata_o = mtimecmp_q[63:32];
            MTIME_LO_OFS:    rdata_o = mtime_q[31:0];
            MTIME_HI_OFS:    rdata_o = mtime_q[63:32];
            default:         rdata_o = '0;
        endcase
    end

    // Level interrupts towards the controller
    assign timer_irq_o = (mtime_q >= mtimecmp_q);
    assign soft_irq_o  = msip_q;

endmodule

// File: logic/irq_ctrl.sv
// ----------------------------------------------------------
// Interrupt controller
// Masks timer, software and external sources into one line
// ----------------------------------------------------------
`timescale 1ns/1ps

module irq_ctrl
    import soc_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic [1:0] irq_ext_i,
    input  logic       timer_irq_i,
    input  logic       soft_irq_i,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  apb_addr_t  paddr_i,
    input  apb_data_t  pwdata_i,
    output apb_data_t  rdata_o,
    output logic       irq_o
);

    logic [1:0] ext_meta_q;
    logic [1:0] ext_sync_q;
    irq_src_t   pending;
    irq_src_t   enable_q;
    irq_src_t   active;
    logic       irq_q;
    logic [2:0] claim_id;
    reg_ofs_t   ofs;
    logic       wr_en;

    assign ofs   = paddr_i[11:0];
    assign wr_en = psel_i & penable_i & pwrite_i;

    // ----------------------------------------------------------
    // External inputs are asynchronous
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ext_meta_q <= '0;
            ext_sync_q <= '0;
        end else begin
            ext_meta_q <= irq_ext_i;
            ext_sync_q <= ext_meta_q;
        end
    end

    // Bit 0 timer, bit 1 software, bits 3:2 external
    assign pending = {ext_sync_q, soft_irq_i, timer_irq_i};
    assign active  = pending & enable_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_q <= '0;
        end else if (wr_en && (ofs == ENABLE_OFS)) begin
            enable_q <= pwdata_i[$bits(irq_src_t)-1:0];
        end
    end

    // Registered output to the core
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= |active;
        end
    end

    assign irq_o = irq_q;

    // ----------------------------------------------------------
    // Claim ID, lowest index wins, zero when idle
    always_comb begin
        claim_id = '0;
        for (int i = $bits(irq_src_t) - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id = 3'(i + 1);
            end
        end
    end

    // Read mux
    always_comb begin
        case (ofs)
            PENDING_OFS: rdata_o = apb_data_t'(pending);
            ENABLE_OFS:  rdata_o = apb_data_t'(enable_q);
            CLAIM_OFS:   rdata_o = apb_data_t'(claim_id);
            default:     rdata_o = '0;
        endcase
    end

endmodule

// File: logic/soc_periph_top.sv
// ----------------------------------------------------------
// Peripheral subsystem top
// APB decoder, memory, CLINT and interrupt controller
// ----------------------------------------------------------
`timescale 1ns/1ps

module soc_periph_top
    import soc_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       rtc_i,
    input  logic [1:0] irq_ext_i,
    input  apb_addr_t  paddr_i,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  apb_data_t  pwdata_i,
    input  apb_strb_t  pstrb_i,
    output apb_data_t  prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,
    output logic       irq_o
);

    logic      sram_psel;
    logic      clint_psel;
    logic      irq_psel;
    apb_data_t sram_rdata;
    apb_data_t clint_rdata;
    apb_data_t irq_rdata;
    logic      timer_irq;
    logic      soft_irq;

    // ----------------------------------------------------------
    // Address decode
    apb_xbar i_apb_xbar (
        .paddr_i       ( paddr_i     ),
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .sram_rdata_i  ( sram_rdata  ),
        .clint_rdata_i ( clint_rdata ),
        .irq_rdata_i   ( irq_rdata   ),
        .sram_psel_o   ( sram_psel   ),
        .clint_psel_o  ( clint_psel  ),
        .irq_psel_o    ( irq_psel    ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   )
    );

    // ----------------------------------------------------------
    // Slaves
    apb_sram i_apb_sram (
        .clk_i     ( clk_i      ),
        .arst_n_i  ( arst_n_i   ),
        .psel_i    ( sram_psel  ),
        .penable_i ( penable_i  ),
        .pwrite_i  ( pwrite_i   ),
        .paddr_i   ( paddr_i    ),
        .pwdata_i  ( pwdata_i   ),
        .pstrb_i   ( pstrb_i    ),
        .rdata_o   ( sram_rdata )
    );

    clint i_clint (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .rtc_i       ( rtc_i       ),
        .psel_i      ( clint_psel  ),
        .penable_i   ( penable_i   ),
        .pwrite_i    ( pwrite_i    ),
        .paddr_i     ( paddr_i     ),
        .pwdata_i    ( pwdata_i    ),
        .pstrb_i     ( pstrb_i     ),
        .rdata_o     ( clint_rdata ),
        .timer_irq_o ( timer_irq   ),
        .soft_irq_o  ( soft_irq    )
    );

    // Interrupt line to the core
    irq_ctrl i_irq_ctrl (
        .clk_i       ( clk_i     ),
        .arst_n_i    ( arst_n_i  ),
        .irq_ext_i   ( irq_ext_i ),
        .timer_irq_i ( timer_irq ),
        .soft_irq_i  ( soft_irq  ),
        .psel_i      ( irq_psel  ),
        .penable_i   ( penable_i ),
        .pwrite_i    ( pwrite_i  ),
        .paddr_i     ( paddr_i   ),
        .pwdata_i    ( pwdata_i  ),
        .rdata_o     ( irq_rdata ),
        .irq_o       ( irq_o     )
    );

endmodule

// File: sim/soc_checker.sv
// ----------------------------------------------------------
// Subsystem checker
// Mirrors memory and register state from the ports and compares
// ----------------------------------------------------------
`timescale 1ns/1ps

module soc_checker
    import soc_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       rtc_i,
    input  logic [1:0] irq_ext_i,
    input  apb_addr_t  paddr_i,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  apb_data_t  pwdata_i,
    input  apb_strb_t  pstrb_i,
    input  apb_data_t  prdata_i,
    input  logic       pready_i,
    input  logic       pslverr_i,
    input  logic       irq_i,
    input  logic       irq_check_i,
    output int         err_cnt_o,
    output int         chk_cnt_o
);

    apb_data_t   mem_m [0:SRAM_WORDS-1];
    mtime_t      cmp_m;
    mtime_t      ticks_m;
    logic        msip_m;
    irq_src_t    en_m;
    logic        rtc_q;
    logic        rst_q;
    logic [32:0] expect_rd;
    int          err_cnt = 0;
    int          chk_cnt = 0;

    assign err_cnt_o = err_cnt;
    assign chk_cnt_o = chk_cnt;

    task report_mismatch(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        err_cnt++;
    endtask

    // Each strobe bit owns one byte lane of the word
    function automatic apb_data_t merge_bytes(apb_data_t old_d, apb_data_t new_d,
                                              apb_strb_t strb);
        apb_data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_d & ~mask) | (new_d & mask);
    endfunction

    // Timer, software, then the two external levels
    function automatic irq_src_t pending_now();
        return {irq_ext_i, msip_m, (ticks_m >= cmp_m)};
    endfunction

    // ----------------------------------------------------------
    // Reference read with the error flag in bit 32
    function automatic logic [32:0] ref_read(apb_addr_t a);
        irq_src_t  act;
        apb_data_t d;
        logic      err;
        d   = '0;
        err = 1'b0;
        act = pending_now() & en_m;
        case (a[15:12])
            REGION_SRAM: begin
                if (a[11:10] != 2'b00) begin
                    err = 1'b1;
                end else begin
                    d = mem_m[a[9:2]];
                end
            end
            REGION_CLINT: begin
                case (a[11:0])
                    MSIP_OFS:        d = {31'd0, msip_m};
                    MTIMECMP_LO_OFS: d = cmp_m[31:0];
                    MTIMECMP_HI_OFS: d = cmp_m[63:32];
                    MTIME_LO_OFS:    d = ticks_m[31:0];
                    MTIME_HI_OFS:    d = ticks_m[63:32];
                    default:         d = '0;
                endcase
            end
            REGION_IRQ: begin
                if (a[11:0] == PENDING_OFS) begin
                    d = {28'd0, pending_now()};
                end else if (a[11:0] == ENABLE_OFS) begin
                    d = {28'd0, en_m};
                end else if (a[11:0] == CLAIM_OFS) begin
                    // First active source from bit 0 upwards
                    for (int i = 0; i < 4; i++) begin
                        if (act[i] && (d == '0)) begin
                            d = 32'(i + 1);
                        end
                    end
                end
            end
            default: err = 1'b1;
        endcase
        return {err, d};
    endfunction

    // ----------------------------------------------------------
    // Observe and compare
    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cmp_m   <= '1;
            ticks_m <= '0;
            msip_m  <= 1'b0;
            en_m    <= '0;
            rtc_q   <= 1'b0;
            rst_q   <= 1'b1;
        end else begin
            rtc_q <= rtc_i;
            rst_q <= 1'b0;
            if (rtc_i && !rtc_q) begin
                ticks_m <= ticks_m + 64'd1;
            end
            if (rst_q && (irq_i || pready_i || pslverr_i)) begin
                report_mismatch("irq, pready or pslverr high right after reset");
            end
            if (psel_i && penable_i) begin
                expect_rd = ref_read(paddr_i);
                chk_cnt++;
                if (pready_i !== 1'b1) begin
                    report_mismatch($sformatf("no pready at address 0x%04h", paddr_i));
                end
                if (pslverr_i !== expect_rd[32]) begin
                    report_mismatch($sformatf("pslverr %b at 0x%04h expected %b",
                                              pslverr_i, paddr_i, expect_rd[32]));
                end
                if (!pwrite_i && (prdata_i !== expect_rd[31:0])) begin
                    report_mismatch($sformatf("read 0x%04h got 0x%08h expected 0x%08h",
                                              paddr_i, prdata_i, expect_rd[31:0]));
                end
                // Mirror writes that reach a slave
                if (pwrite_i && !expect_rd[32]) begin
                    case (paddr_i[15:12])
                        REGION_SRAM: begin
                            mem_m[paddr_i[9:2]] <= merge_bytes(mem_m[paddr_i[9:2]],
                                                               pwdata_i, pstrb_i);
                        end
                        REGION_CLINT: begin
                            if (paddr_i[11:0] == MSIP_OFS && pstrb_i[0]) begin
                                msip_m <= pwdata_i[0];
                            end else if (paddr_i[11:0] == MTIMECMP_LO_OFS) begin
                                cmp_m[31:0] <= merge_bytes(cmp_m[31:0], pwdata_i, pstrb_i);
                            end else if (paddr_i[11:0] == MTIMECMP_HI_OFS) begin
                                cmp_m[63:32] <= merge_bytes(cmp_m[63:32], pwdata_i, pstrb_i);
                            end
                        end
                        REGION_IRQ: begin
                            if (paddr_i[11:0] == ENABLE_OFS) begin
                                en_m <= pwdata_i[3:0];
                            end
                        end
                        default: begin
                        end
                    endcase
                end
            end
            // Sampled irq check once the stimulus has settled
            if (irq_check_i) begin
                chk_cnt++;
                if (irq_i !== (|(pending_now() & en_m))) begin
                    report_mismatch($sformatf("irq_o is %b, pending %b enable %b",
                                              irq_i, pending_now(), en_m));
                end
            end
        end
    end

endmodule

// File: sim/tb_soc_periph.sv
// ----------------------------------------------------------
// Peripheral subsystem testbench
// Drives APB, rtc and external interrupts, reports per test
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_soc_periph
    import soc_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    // Sequence needs under 2000 cycles, limit leaves ample room
    localparam int TEST_BUDGET  = 2000;
    localparam int MAX_CYCLES   = 2 * TEST_BUDGET + 1000;

    localparam apb_addr_t ENABLE_ADDR  = {REGION_IRQ, ENABLE_OFS};
    localparam apb_addr_t PENDING_ADDR = {REGION_IRQ, PENDING_OFS};
    localparam apb_addr_t CLAIM_ADDR   = {REGION_IRQ, CLAIM_OFS};
    localparam apb_addr_t CMP_LO_ADDR  = {REGION_CLINT, MTIMECMP_LO_OFS};
    localparam apb_addr_t CMP_HI_ADDR  = {REGION_CLINT, MTIMECMP_HI_OFS};

    logic       clk;
    logic       arst_n;
    logic       rtc;
    logic [1:0] irq_ext;
    apb_addr_t  paddr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_data_t  pwdata;
    apb_strb_t  pstrb;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;
    logic       irq;
    logic       irq_check;
    int         err_cnt;
    int         chk_cnt;
    int         err_before = 0;
    int         cycle_cnt = 0;
    logic [15:0] lfsr_q = 16'd2;
    mtime_t     rtc_count = '0;
    apb_addr_t  mem_addr [0:7];

    soc_periph_top uut (
        .clk_i(clk), .arst_n_i(arst_n), .rtc_i(rtc), .irq_ext_i(irq_ext),
        .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .pwdata_i(pwdata), .pstrb_i(pstrb), .prdata_o(prdata), .pready_o(pready),
        .pslverr_o(pslverr), .irq_o(irq)
    );

    soc_checker chk (
        .clk_i(clk), .arst_n_i(arst_n), .rtc_i(rtc), .irq_ext_i(irq_ext),
        .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .pwdata_i(pwdata), .pstrb_i(pstrb), .prdata_i(prdata), .pready_i(pready),
        .pslverr_i(pslverr), .irq_i(irq), .irq_check_i(irq_check),
        .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycle_cnt);
            $display("Errors found");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function apb_data_t get_bits(input int n);
        apb_data_t res;
        res = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            res = {res[30:0], lfsr_q[0]};
        end
        return res;
    endfunction

    // ----------------------------------------------------------
    // APB transfer, setup then access until pready
    task automatic apb_xfer(input apb_addr_t addr, input logic wr, input apb_data_t data,
                            input apb_strb_t strb);
        @(negedge clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = data;
        pstrb   = strb;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready) @(posedge clk);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data,
                             input apb_strb_t strb);
        apb_xfer(addr, 1'b1, data, strb);
    endtask

    task automatic apb_read(input apb_addr_t addr);
        apb_xfer(addr, 1'b0, '0, 4'h0);
    endtask

    // Edges at least 4 cycles apart
    task automatic rtc_pulse();
        @(negedge clk);
        rtc = 1'b1;
        repeat (4) @(negedge clk);
        rtc = 1'b0;
        repeat (4) @(negedge clk);
        rtc_count = rtc_count + 64'd1;
    endtask

    task automatic request_irq_check();
        repeat (5) @(negedge clk);
        irq_check = 1'b1;
        @(negedge clk);
        irq_check = 1'b0;
    endtask

    task automatic end_test(input string name);
        $display("[%0t] test %s done, %0d mismatches", $time, name, err_cnt - err_before);
        err_before = err_cnt;
    endtask

    // ----------------------------------------------------------
    // Test sequence
    initial begin : stimulus
        apb_data_t r;
        region_t   rgn;
        logic [1:0] hb;
        arst_n    = 1'b0;
        rtc       = 1'b0;
        irq_ext   = '0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        pstrb     = '0;
        irq_check = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;

        // Full word first, then a strobed overwrite
        for (int i = 0; i < 8; i++) begin
            r = get_bits(8);
            mem_addr[i] = {4'h0, 2'b00, r[7:0], 2'b00};
            apb_write(mem_addr[i], get_bits(32), 4'hF);
            r = get_bits(4);
            apb_write(mem_addr[i], get_bits(32), r[3:0]);
        end
        for (int i = 0; i < 8; i++) begin
            apb_read(mem_addr[i]);
        end
        end_test("memory_rw");

        for (int i = 0; i < 4; i++) begin
            r = get_bits(4);
            rgn = (r[3:0] < 4'd3) ? (r[3:0] + 4'd3) : r[3:0];
            r = get_bits(12);
            apb_write({rgn, r[11:0]}, get_bits(32), 4'hF);
            apb_read({rgn, r[11:0]});
            // Hole above the memory aliases a written word
            r = get_bits(2);
            hb = (r[1:0] == 2'b00) ? 2'b11 : r[1:0];
            apb_write({4'h0, hb, mem_addr[i][9:0]}, get_bits(32), 4'hF);
            apb_read({4'h0, hb, mem_addr[i][9:0]});
            apb_read(mem_addr[i]);
        end
        end_test("decode_error");

        repeat (5) rtc_pulse();
        apb_read({REGION_CLINT, MTIME_LO_OFS});
        apb_read({REGION_CLINT, MTIME_HI_OFS});
        end_test("mtime_count");

        apb_write(ENABLE_ADDR, 32'h1, 4'hF);
        apb_write(CMP_LO_ADDR, rtc_count[31:0] + 32'd3, 4'hF);
        apb_write(CMP_HI_ADDR, 32'd0, 4'hF);
        request_irq_check();
        repeat (2) rtc_pulse();
        request_irq_check();
        rtc_pulse();
        request_irq_check();
        apb_read(CLAIM_ADDR);
        apb_write(CMP_LO_ADDR, rtc_count[31:0] + 32'd100, 4'hF);
        request_irq_check();
        apb_read(CLAIM_ADDR);
        end_test("timer_irq");

        apb_write(ENABLE_ADDR, 32'h0, 4'hF);
        apb_write({REGION_CLINT, MSIP_OFS}, 32'h1, 4'h1);
        request_irq_check();
        apb_read(PENDING_ADDR);
        apb_read(CLAIM_ADDR);
        irq_ext = 2'b10;
        request_irq_check();
        apb_read(PENDING_ADDR);
        apb_write(ENABLE_ADDR, 32'hA, 4'hF);
        request_irq_check();
        apb_read(CLAIM_ADDR);
        apb_write(ENABLE_ADDR, 32'h8, 4'hF);
        request_irq_check();
        apb_read(CLAIM_ADDR);
        irq_ext = 2'b01;
        apb_write(ENABLE_ADDR, 32'hC, 4'hF);
        request_irq_check();
        apb_read(CLAIM_ADDR);
        apb_write({REGION_CLINT, MSIP_OFS}, 32'h0, 4'h1);
        irq_ext = 2'b00;
        request_irq_check();
        apb_read(PENDING_ADDR);
        end_test("soft_ext_mask");

        $display("Summary: %0d checks, %0d mismatches", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verilog.f
logic/soc_pkg.sv
logic/apb_xbar.sv
logic/apb_sram.sv
logic/clint.sv
logic/irq_ctrl.sv
logic/soc_periph_top.sv
sim/soc_checker.sv
sim/tb_soc_periph.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_soc_periph -f verilog.f -o tb_soc_periph || exit 1
sim_out=$(./obj_dir/tb_soc_periph)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "No errors" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
